//--- design/fetch_load_cfg.svh
`ifndef FETCH_LOAD_CFG_SVH
`define FETCH_LOAD_CFG_SVH

// byte address width
`define ADDR_W 32

// words per cache line, 2 to 16 as a power of two
`define LINE_WORDS 4

// start of the region the memory answers with SLVERR
`define ERR_BASE 32'hF000_0000

`endif

//--- design/axi_rd_pkg.sv
`include "fetch_load_cfg.svh"

// AXI read channel field types, shared by every master and slave on the read path
package axi_rd_pkg;

	typedef logic [`ADDR_W-1:0] addr_t;  // byte address
	typedef logic [31:0] data_t;         // one data beat
	typedef logic [1:0] resp_t;
	typedef logic [7:0] len_t;           // beats minus one
	typedef logic [1:0] burst_t;
	typedef logic [2:0] size_t;          // log2 of bytes per beat

	// response codes
	localparam resp_t OKAY = 2'b00;
	localparam resp_t SLVERR = 2'b10;

	localparam burst_t INCR = 2'b01;  // incrementing burst

	// full word beat
	localparam size_t SIZE_WORD = 3'd2;
	localparam int BEAT_BYTES = 4;

endpackage

//--- design/mem_req_pkg.sv
`include "fetch_load_cfg.svh"

// requester side types: cache line, load size and the state machines
package mem_req_pkg;

	// word 0 sits in the low bits
	typedef axi_rd_pkg::data_t [`LINE_WORDS-1:0] line_t;

	// same codes as AXI arsize, so the load unit forwards them as they are
	typedef enum logic [2:0] {
		LD_BYTE = 3'd0,
		LD_HALF = 3'd1,
		LD_WORD = 3'd2
	} ld_size_e;

	typedef enum logic [1:0] {
		RF_IDLE,
		RF_ADDR,  // arvalid out, waiting on arready
		RF_DATA   // collecting beats
	} refill_state_e;

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_ADDR,
		LS_DATA
	} load_state_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_REFILL,  // refill engine owns the bus
		ARB_LOAD
	} arb_state_e;

endpackage

//--- design/axi_rd_if.sv
`timescale 1ns/1ps

// AXI read address and read data channels
interface axi_rd_if;
	import axi_rd_pkg::*;

	addr_t araddr;
	logic arvalid;
	logic arready;
	len_t arlen;
	size_t arsize;
	burst_t arburst;

	data_t rdata;
	resp_t rresp;
	logic rvalid;
	logic rready;
	logic rlast;

	// requester side
	modport master (
		output araddr, arvalid, arlen, arsize, arburst, rready,
		input arready, rdata, rresp, rvalid, rlast
	);

	// memory side, or the arbiter facing one requester
	modport slave (
		input araddr, arvalid, arlen, arsize, arburst, rready,
		output arready, rdata, rresp, rvalid, rlast
	);

endinterface

//--- design/line_refill.sv
`timescale 1ns/1ps
`include "fetch_load_cfg.svh"

// fetches one instruction cache line as a single INCR burst
module line_refill (
	input logic clk,
	input logic rst,
	input logic miss_valid,
	input axi_rd_pkg::addr_t miss_addr,
	output logic refill_busy,
	output logic refill_done,
	output mem_req_pkg::line_t refill_line,
	output logic refill_err,
	axi_rd_if.master bus
);
	import axi_rd_pkg::*;
	import mem_req_pkg::*;

	localparam int BEAT_W = $clog2(`LINE_WORDS);
	localparam int OFS_W = $clog2(`LINE_WORDS * BEAT_BYTES);  // byte offset inside a line

	refill_state_e state;
	addr_t line_addr;
	logic [BEAT_W-1:0] beat_cnt;  // next word slot to fill
	line_t line_q;
	logic err_q;
	logic done_q;
	logic beat;

	assign beat = bus.rvalid && bus.rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RF_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				RF_IDLE: begin
					if (miss_valid)
						state <= RF_ADDR;
				end
				RF_ADDR: begin
					if (bus.arready)
						state <= RF_DATA;
				end
				RF_DATA: begin
					if (beat && bus.rlast) begin
						state <= RF_IDLE;
						done_q <= 1'b1;  // busy drops on the same cycle
					end
				end
				default: state <= RF_IDLE;
			endcase
		end
	end

	// address capture and line assembly
	always_ff @(posedge clk) begin
		if (state == RF_IDLE && miss_valid) begin
			line_addr <= {miss_addr[`ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
			beat_cnt <= '0;
			err_q <= 1'b0;
		end else if (beat) begin
			line_q[beat_cnt] <= bus.rdata;
			beat_cnt <= beat_cnt + 1'b1;
			err_q <= err_q | (bus.rresp != OKAY);  // any bad beat spoils the line
		end
	end

	assign bus.araddr = line_addr;
	assign bus.arvalid = (state == RF_ADDR);
	assign bus.arlen = len_t'(`LINE_WORDS - 1);
	assign bus.arsize = SIZE_WORD;
	assign bus.arburst = INCR;
	assign bus.rready = (state == RF_DATA);  // never back-pressures the slave

	assign refill_busy = (state != RF_IDLE);
	assign refill_done = done_q;
	assign refill_line = line_q;
	assign refill_err = err_q;

	// request must hold while the slave stalls arready
	a_ar_stable: assert property (@(posedge clk) disable iff (rst)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr)
			&& $stable(bus.arlen));

	// slave and arbiter agree on the burst length
	a_rlast_pos: assert property (@(posedge clk) disable iff (rst)
		beat |-> (bus.rlast == (beat_cnt == BEAT_W'(`LINE_WORDS - 1))));

endmodule

//--- design/load_unit.sv
`timescale 1ns/1ps
`include "fetch_load_cfg.svh"

// single-beat loads of byte, half or word, with alignment and extension
module load_unit (
	input logic clk,
	input logic rst,
	input logic load_valid,
	input axi_rd_pkg::addr_t load_addr,
	input mem_req_pkg::ld_size_e load_size,
	input logic load_signed,
	output logic load_busy,
	output logic load_done,
	output axi_rd_pkg::data_t load_data,
	output logic load_err,
	axi_rd_if.master bus
);
	import axi_rd_pkg::*;
	import mem_req_pkg::*;

	load_state_e state;
	addr_t word_addr;
	logic [1:0] ofs_q;  // byte lane within the word
	ld_size_e size_q;
	logic sign_q;
	data_t data_q;
	logic err_q;
	logic done_q;
	logic beat;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;
	data_t ext;

	assign beat = bus.rvalid && bus.rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LS_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= beat;  // one beat per load
			case (state)
				LS_IDLE: begin
					if (load_valid)
						state <= LS_ADDR;
				end
				LS_ADDR: begin
					if (bus.arready)
						state <= LS_DATA;
				end
				LS_DATA: begin
					if (beat)
						state <= LS_IDLE;
				end
				default: state <= LS_IDLE;
			endcase
		end
	end

	// pick the lane, misaligned halves round down
	always_comb begin
		byte_sel = bus.rdata[{ofs_q, 3'b000} +: 8];
		half_sel = bus.rdata[{ofs_q[1], 4'b0000} +: 16];
		case (size_q)
			LD_BYTE: ext = {{24{sign_q & byte_sel[7]}}, byte_sel};
			LD_HALF: ext = {{16{sign_q & half_sel[15]}}, half_sel};
			default: ext = bus.rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == LS_IDLE && load_valid) begin
			word_addr <= {load_addr[`ADDR_W-1:2], 2'b00};
			ofs_q <= load_addr[1:0];
			size_q <= load_size;
			sign_q <= load_signed;
		end
		if (beat) begin
			data_q <= ext;
			err_q <= (bus.rresp != OKAY);
		end
	end

	assign bus.araddr = word_addr;
	assign bus.arvalid = (state == LS_ADDR);
	assign bus.arlen = '0;
	assign bus.arsize = size_t'(size_q);  // enum codes match AXI
	assign bus.arburst = INCR;
	assign bus.rready = (state == LS_DATA);

	assign load_busy = (state != LS_IDLE);
	assign load_done = done_q;
	assign load_data = data_q;
	assign load_err = err_q;

	// an out of range size from the core must never reach the bus
	a_size_legal: assert property (@(posedge clk) disable iff (rst)
		bus.arvalid |-> bus.arsize <= SIZE_WORD);

	// single beat, so the slave must mark it last
	a_single_beat: assert property (@(posedge clk) disable iff (rst)
		beat |-> bus.rlast);

endmodule

//--- design/rd_bus_arbiter.sv
`timescale 1ns/1ps

// fixed priority read arbiter giving the refill engine the first pick
module rd_bus_arbiter (
	input logic clk,
	input logic rst,
	axi_rd_if.slave refill_port,
	axi_rd_if.slave load_port,
	output axi_rd_pkg::addr_t m_araddr,
	output logic m_arvalid,
	input logic m_arready,
	output axi_rd_pkg::len_t m_arlen,
	output axi_rd_pkg::size_t m_arsize,
	output axi_rd_pkg::burst_t m_arburst,
	input axi_rd_pkg::data_t m_rdata,
	input axi_rd_pkg::resp_t m_rresp,
	input logic m_rvalid,
	output logic m_rready,
	input logic m_rlast
);
	import axi_rd_pkg::*;
	import mem_req_pkg::*;

	arb_state_e state;
	arb_state_e next_state;
	logic last_beat;  // granted master takes its final beat

	// loads are single beat, so any accepted beat ends them
	assign last_beat = m_rvalid && m_rready && (m_rlast || state == ARB_LOAD);

	always_comb begin
		next_state = state;
		case (state)
			ARB_IDLE: begin
				if (refill_port.arvalid)
					next_state = ARB_REFILL;
				else if (load_port.arvalid)
					next_state = ARB_LOAD;
			end
			ARB_REFILL, ARB_LOAD: begin
				if (last_beat)
					next_state = ARB_IDLE;  // one idle cycle follows
			end
			default: next_state = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= ARB_IDLE;
		else
			state <= next_state;
	end

	// the loser sees a quiet channel
	always_comb begin
		m_araddr = '0;
		m_arvalid = 1'b0;
		m_arlen = '0;
		m_arsize = '0;
		m_arburst = '0;
		m_rready = 1'b0;

		refill_port.arready = 1'b0;
		refill_port.rdata = '0;
		refill_port.rresp = OKAY;
		refill_port.rvalid = 1'b0;
		refill_port.rlast = 1'b0;

		load_port.arready = 1'b0;
		load_port.rdata = '0;
		load_port.rresp = OKAY;
		load_port.rvalid = 1'b0;
		load_port.rlast = 1'b0;

		case (state)
			ARB_REFILL: begin
				m_araddr = refill_port.araddr;
				m_arvalid = refill_port.arvalid;
				m_arlen = refill_port.arlen;
				m_arsize = refill_port.arsize;
				m_arburst = refill_port.arburst;
				m_rready = refill_port.rready;
				refill_port.arready = m_arready;
				refill_port.rdata = m_rdata;
				refill_port.rresp = m_rresp;
				refill_port.rvalid = m_rvalid;
				refill_port.rlast = m_rlast;
			end
			ARB_LOAD: begin
				m_araddr = load_port.araddr;
				m_arvalid = load_port.arvalid;
				m_arlen = load_port.arlen;
				m_arsize = load_port.arsize;
				m_arburst = load_port.arburst;
				m_rready = load_port.rready;
				load_port.arready = m_arready;
				load_port.rdata = m_rdata;
				load_port.rresp = m_rresp;
				load_port.rvalid = m_rvalid;
				load_port.rlast = m_rlast;
			end
			default: ;
		endcase
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		state == ARB_IDLE |-> !m_arvalid);

	// a granted master keeps the bus until a beat marked last is taken
	a_grant_hold: assert property (@(posedge clk) disable iff (rst)
		state != ARB_IDLE && !(m_rvalid && m_rready && m_rlast) |=> state == $past(state));

endmodule

//--- design/fetch_load_top.sv
`timescale 1ns/1ps

// read-side memory front end: line refill and load unit sharing one AXI read port
module fetch_load_top (
	input logic clk,
	input logic rst,

	input logic miss_valid,
	input axi_rd_pkg::addr_t miss_addr,
	output logic refill_busy,
	output logic refill_done,
	output mem_req_pkg::line_t refill_line,
	output logic refill_err,

	input logic load_valid,
	input axi_rd_pkg::addr_t load_addr,
	input mem_req_pkg::ld_size_e load_size,
	input logic load_signed,
	output logic load_busy,
	output logic load_done,
	output axi_rd_pkg::data_t load_data,
	output logic load_err,

	output axi_rd_pkg::addr_t m_araddr,
	output logic m_arvalid,
	input logic m_arready,
	output axi_rd_pkg::len_t m_arlen,
	output axi_rd_pkg::size_t m_arsize,
	output axi_rd_pkg::burst_t m_arburst,
	input axi_rd_pkg::data_t m_rdata,
	input axi_rd_pkg::resp_t m_rresp,
	input logic m_rvalid,
	output logic m_rready,
	input logic m_rlast
);

	axi_rd_if refill_bus ();
	axi_rd_if load_bus ();

	line_refill u_refill (
		.clk(clk),
		.rst(rst),
		.miss_valid(miss_valid),
		.miss_addr(miss_addr),
		.refill_busy(refill_busy),
		.refill_done(refill_done),
		.refill_line(refill_line),
		.refill_err(refill_err),
		.bus(refill_bus.master)
	);

	load_unit u_load (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_size(load_size),
		.load_signed(load_signed),
		.load_busy(load_busy),
		.load_done(load_done),
		.load_data(load_data),
		.load_err(load_err),
		.bus(load_bus.master)
	);

	rd_bus_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.refill_port(refill_bus.slave),
		.load_port(load_bus.slave),
		.m_araddr(m_araddr),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_arlen(m_arlen),
		.m_arsize(m_arsize),
		.m_arburst(m_arburst),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready),
		.m_rlast(m_rlast)
	);

endmodule

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps
`include "fetch_load_cfg.svh"

// AXI read slave, data follows a fixed address rule, random stalls on both channels
module axi_mem_model (
	input logic clk,
	input logic rst,
	input axi_rd_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	input axi_rd_pkg::len_t arlen,
	input axi_rd_pkg::size_t arsize,
	input axi_rd_pkg::burst_t arburst,
	output axi_rd_pkg::data_t rdata,
	output axi_rd_pkg::resp_t rresp,
	output logic rvalid,
	input logic rready,
	output logic rlast
);
	import axi_rd_pkg::*;

	logic [31:0] seed;
	addr_t cur_addr;  // word aligned start of the burst
	len_t cur_len;
	logic ar_hs;
	logic r_hs;
	logic in_burst;
	logic [1:0] stall;  // cycles left before the next arready or rvalid
	int beat_idx;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin
		seed = 32'd53706;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		rresp = OKAY;
		stall = 2'd0;
		in_burst = 1'b0;
		beat_idx = 0;
	end

	// handshakes as seen at the rising edge
	always @(posedge clk) begin
		ar_hs <= arvalid && arready;
		r_hs <= rvalid && rready;
		if (arvalid && arready) begin
			cur_addr <= {araddr[`ADDR_W-1:2], 2'b00};
			cur_len <= arlen;
		end
	end

	// responses change on the falling edge only
	always @(negedge clk) begin : respond
		addr_t baddr;
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			in_burst = 1'b0;
			stall = 2'd0;
		end else if (!in_burst) begin
			if (ar_hs) begin
				arready <= 1'b0;
				in_burst = 1'b1;
				beat_idx = 0;
				seed = lcg_step(seed);
				stall = seed[31:30];
			end else if (arvalid && !arready) begin
				if (stall == 2'd0)
					arready <= 1'b1;
				else
					stall = stall - 2'd1;
			end
		end else begin
			if (r_hs) begin
				rvalid <= 1'b0;
				rlast <= 1'b0;
				beat_idx = beat_idx + 1;
				seed = lcg_step(seed);
				stall = seed[31:30];
				if (beat_idx > int'(cur_len))
					in_burst = 1'b0;  // burst done, next stall is for arready
			end
			if (in_burst && (r_hs || !rvalid)) begin
				if (stall == 2'd0) begin
					baddr = cur_addr + addr_t'(4 * beat_idx);
					rvalid <= 1'b1;
					rlast <= (beat_idx == int'(cur_len));
					if (baddr >= `ERR_BASE) begin
						rresp <= SLVERR;
						rdata <= '0;
					end else begin
						rresp <= OKAY;
						rdata <= baddr * 32'h9E37_79B1;
					end
				end else begin
					stall = stall - 2'd1;
				end
			end
		end
	end

endmodule

//--- sim/tb_fetch_load.sv
`timescale 1ns/1ps
`include "fetch_load_cfg.svh"

module tb_fetch_load;
	import axi_rd_pkg::*;
	import mem_req_pkg::*;

	localparam int LINE_BYTES = `LINE_WORDS * 4;
	localparam int N_REFILL = 16;  // refills alone
	localparam int N_LOAD = 24;    // every size, sign mode and offset
	localparam int N_PAIRS = 20;
	localparam int N_MIX = 300;
	localparam int N_ERR = 6;
	localparam int TOTAL_REQ = N_REFILL + N_LOAD + 2 * N_PAIRS + N_MIX + N_ERR;

	logic clk = 1'b0;
	logic rst;
	logic miss_valid;
	addr_t miss_addr;
	logic refill_busy;
	logic refill_done;
	line_t refill_line;
	logic refill_err;
	logic load_valid;
	addr_t load_addr;
	ld_size_e load_size;
	logic load_signed;
	logic load_busy;
	logic load_done;
	data_t load_data;
	logic load_err;
	addr_t m_araddr;
	logic m_arvalid;
	logic m_arready;
	len_t m_arlen;
	size_t m_arsize;
	burst_t m_arburst;
	data_t m_rdata;
	resp_t m_rresp;
	logic m_rvalid;
	logic m_rready;
	logic m_rlast;

	logic [31:0] seed = 32'd53706;
	addr_t refill_exp[$];  // outstanding refills in issue order
	addr_t load_exp_addr[$];
	ld_size_e load_exp_size[$];
	logic load_exp_sign[$];
	int refill_req_cnt = 0;
	int refill_done_cnt = 0;
	int load_req_cnt = 0;
	int load_done_cnt = 0;
	time refill_done_t = 0;
	time load_done_t = 0;
	logic refill_ar_open = 1'b0;  // accepted, address phase still to come
	logic load_ar_open = 1'b0;
	addr_t refill_ar_addr;
	addr_t load_ar_addr;
	ld_size_e load_ar_size;

	fetch_load_top DUT (.*);

	axi_mem_model u_mem (
		.clk(clk),
		.rst(rst),
		.araddr(m_araddr),
		.arvalid(m_arvalid),
		.arready(m_arready),
		.arlen(m_arlen),
		.arsize(m_arsize),
		.arburst(m_arburst),
		.rdata(m_rdata),
		.rresp(m_rresp),
		.rvalid(m_rvalid),
		.rready(m_rready),
		.rlast(m_rlast)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// aligned address times the golden ratio constant
	function automatic data_t ref_word(input addr_t a);
		return {a[31:2], 2'b00} * 32'h9E37_79B1;
	endfunction

	function automatic line_t ref_line(input addr_t a);
		line_t l;
		addr_t base;
		base = a & ~addr_t'(LINE_BYTES - 1);
		for (int i = 0; i < `LINE_WORDS; i++)
			l[i] = ref_word(base + addr_t'(4 * i));
		return l;
	endfunction

	function automatic data_t ref_load(input addr_t a, input ld_size_e s, input logic sg);
		data_t w;
		logic [7:0] b;
		logic [15:0] h;
		w = ref_word(a);
		b = w[8 * a[1:0] +: 8];
		h = w[16 * a[1] +: 16];  // odd half offsets round down
		case (s)
			LD_BYTE: return sg ? {{24{b[7]}}, b} : {24'h0, b};
			LD_HALF: return sg ? {{16{h[15]}}, h} : {16'h0, h};
			default: return w;
		endcase
	endfunction

	function automatic logic ref_err(input addr_t a);
		return a >= `ERR_BASE;
	endfunction

	// AXI size code is log2 of the bytes per beat
	function automatic size_t axi_size_of(input ld_size_e s);
		case (s)
			LD_BYTE: return 3'd0;
			LD_HALF: return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic roll(output logic [31:0] r);
		seed = lcg_step(seed);
		r = {seed[15:0], seed[31:16]};  // weak low bits moved up
	endtask

	task automatic pick_miss(output addr_t a);
		logic [31:0] r;
		roll(r);
		a = {1'b0, r[30:0]};  // clear of the error region
	endtask

	task automatic pick_load(output addr_t a, output ld_size_e s, output logic sg);
		logic [31:0] r;
		pick_miss(a);
		roll(r);
		case (r[31:30])
			2'd0: s = LD_BYTE;
			2'd1: s = LD_HALF;
			default: s = LD_WORD;
		endcase
		sg = r[29];
	endtask

	// one-cycle pulses driven just after a falling edge with the busy levels low
	task automatic drive_requests(input logic do_miss, input addr_t maddr, input logic do_load,
			input addr_t laddr, input ld_size_e lsize, input logic lsign);
		if (do_miss) begin
			miss_valid = 1'b1;
			miss_addr = maddr;
			refill_exp.push_back(maddr);
			refill_ar_open = 1'b1;
			refill_ar_addr = maddr;
			refill_req_cnt++;
		end
		if (do_load) begin
			load_valid = 1'b1;
			load_addr = laddr;
			load_size = lsize;
			load_signed = lsign;
			load_exp_addr.push_back(laddr);
			load_exp_size.push_back(lsize);
			load_exp_sign.push_back(lsign);
			load_ar_open = 1'b1;
			load_ar_addr = laddr;
			load_ar_size = lsize;
			load_req_cnt++;
		end
		@(negedge clk);
		miss_valid = 1'b0;
		load_valid = 1'b0;
		if (do_miss)
			check_val("refill_busy", refill_busy, 1'b1);
		if (do_load)
			check_val("load_busy", load_busy, 1'b1);
	endtask

	task automatic wait_idle();
		while (refill_done_cnt != refill_req_cnt || load_done_cnt != load_req_cnt)
			@(negedge clk);
	endtask

	// read address channel as the memory takes it
	always @(posedge clk) begin : compare_ar
		if (!rst && m_arvalid && m_arready) begin
			check_val("m_arburst", m_arburst, 32'h1);  // INCR
			if (refill_ar_open && m_araddr == (refill_ar_addr & ~addr_t'(LINE_BYTES - 1))) begin
				refill_ar_open = 1'b0;
				check_val("m_arlen", m_arlen, `LINE_WORDS - 1);
				check_val("m_arsize", m_arsize, 32'd2);  // full word beats
			end else if (load_ar_open) begin
				load_ar_open = 1'b0;
				check_val("m_araddr", m_araddr, load_ar_addr & ~addr_t'(3));
				check_val("m_arlen", m_arlen, 32'd0);
				check_val("m_arsize", m_arsize, axi_size_of(load_ar_size));
			end else begin
				stop_run("address handshake with no request waiting for its address phase");
			end
		end
	end

	always @(posedge clk) begin : compare_refill
		addr_t a;
		line_t exp_line;
		if (!rst && refill_done) begin
			if (refill_exp.size() == 0) begin
				stop_run("refill_done pulsed with no refill outstanding");
			end else begin
				a = refill_exp.pop_front();
				exp_line = ref_line(a);
				check_val("refill_err", refill_err, ref_err(a));
				if (!ref_err(a))
					for (int i = 0; i < `LINE_WORDS; i++)
						check_val($sformatf("refill_line[%0d]", i), refill_line[i], exp_line[i]);
				refill_done_cnt++;
				refill_done_t = $time;
			end
		end
	end

	always @(posedge clk) begin : compare_load
		addr_t a;
		ld_size_e s;
		logic sg;
		if (!rst && load_done) begin
			if (load_exp_addr.size() == 0) begin
				stop_run("load_done pulsed with no load outstanding");
			end else begin
				a = load_exp_addr.pop_front();
				s = load_exp_size.pop_front();
				sg = load_exp_sign.pop_front();
				check_val("load_err", load_err, ref_err(a));
				if (!ref_err(a))
					check_val("load_data", load_data, ref_load(a, s, sg));
				load_done_cnt++;
				load_done_t = $time;
			end
		end
	end

	// budget per request plus reset
	initial begin
		repeat (10 + 200 * TOTAL_REQ) @(posedge clk);
		stop_run("timeout: no done pulse arrived for an outstanding request");
	end

	initial begin
		logic [31:0] r;
		addr_t a;
		addr_t la;
		ld_size_e s;
		logic sg;
		int mixed;
		logic do_m;
		logic do_l;

		rst = 1'b1;
		miss_valid = 1'b0;
		miss_addr = '0;
		load_valid = 1'b0;
		load_addr = '0;
		load_size = LD_WORD;
		load_signed = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// refills alone with every other address line aligned
		for (int i = 0; i < N_REFILL; i++) begin
			pick_miss(a);
			if (i % 2 == 0)
				a = a & ~addr_t'(LINE_BYTES - 1);
			drive_requests(1'b1, a, 1'b0, '0, LD_WORD, 1'b0);
			wait_idle();
		end

		for (int sz = 0; sz < 3; sz++)
			for (int sgn = 0; sgn < 2; sgn++)
				for (int ofs = 0; ofs < 4; ofs++) begin
					pick_miss(a);
					a[1:0] = ofs[1:0];
					drive_requests(1'b0, '0, 1'b1, a, ld_size_e'(sz), sgn[0]);
					wait_idle();
				end

		// same-cycle requests where the refill wins the bus
		for (int i = 0; i < N_PAIRS; i++) begin
			pick_miss(a);
			pick_load(la, s, sg);
			drive_requests(1'b1, a, 1'b1, la, s, sg);
			wait_idle();
			if (refill_done_t >= load_done_t)
				stop_run("load_done came before refill_done on a simultaneous request");
		end

		mixed = 0;
		while (mixed < N_MIX) begin
			roll(r);
			do_m = !refill_busy && r[0];
			do_l = !load_busy && r[1] && (mixed + int'(do_m) < N_MIX);
			if (do_m || do_l) begin
				pick_miss(a);
				pick_load(la, s, sg);
				drive_requests(do_m, a, do_l, la, s, sg);
				mixed = mixed + int'(do_m) + int'(do_l);
			end else begin
				@(negedge clk);
			end
		end
		wait_idle();

		// error region first and clean traffic with the flags low afterwards
		drive_requests(1'b1, `ERR_BASE + 32'h44, 1'b0, '0, LD_WORD, 1'b0);
		wait_idle();
		drive_requests(1'b0, '0, 1'b1, 32'hFFFF_FFFE, LD_HALF, 1'b1);
		wait_idle();
		drive_requests(1'b1, 32'hFFFF_FFF8, 1'b1, `ERR_BASE, LD_WORD, 1'b0);
		wait_idle();
		pick_miss(a);
		pick_load(la, s, sg);
		drive_requests(1'b1, a, 1'b1, la, s, sg);
		wait_idle();

		repeat (20) @(negedge clk);
		if (refill_done_cnt == refill_req_cnt && load_done_cnt == load_req_cnt) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run("number of done pulses does not match the accepted requests");
		end
	end

endmodule

//--- tb.f
+incdir+design
design/axi_rd_pkg.sv
design/mem_req_pkg.sv
design/axi_rd_if.sv
design/line_refill.sv
design/load_unit.sv
design/rd_bus_arbiter.sv
design/fetch_load_top.sv
sim/axi_mem_model.sv
sim/tb_fetch_load.sv

//--- Bender.yml
package:
  name: fetch_load

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/axi_rd_pkg.sv
      - design/mem_req_pkg.sv
      - design/axi_rd_if.sv
      - design/line_refill.sv
      - design/load_unit.sv
      - design/rd_bus_arbiter.sv
      - design/fetch_load_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/axi_mem_model.sv
      - sim/tb_fetch_load.sv
